// ==== verilog/ghtPkg.sv ====
package ghtPkg;

    // table geometry
    localparam int IndexWidth   = 16;
    localparam int HistWidth    = 8;
    localparam int CounterWidth = 2;
    localparam int BankCount    = 8;
    localparam int BankBits     = 3;
    localparam int RowCount     = 32;
    localparam int RowBits      = 5;
    localparam int EntryCount   = 256;
    localparam int EntryBits    = 8;
    localparam int RowWidth     = EntryCount * CounterWidth;

    typedef logic [IndexWidth-1:0]   ghtIndexT;
    typedef logic [HistWidth-1:0]    historyT;
    typedef logic [CounterWidth-1:0] counterT;
    typedef logic [BankBits-1:0]     bankT;
    typedef logic [RowBits-1:0]      rowT;
    typedef logic [EntryBits-1:0]    entryT;

    typedef enum logic [1:0] {
        schedInit,
        schedRun,
        schedSaved
    } schedStateT;

    // bank is index bits 7:6 above bit 0
    function automatic bankT indexBank(ghtIndexT idx);
        return {idx[7:6], idx[0]};
    endfunction

    function automatic rowT indexRow(ghtIndexT idx);
        return idx[5:1];
    endfunction

    function automatic entryT indexEntry(ghtIndexT idx);
        return idx[15:8];
    endfunction

endpackage

// ==== verilog/historyBank.sv ====
module historyBank (
    input  logic            clk,
    input  logic            writeEn,
    input  logic            clearEn,
    input  ghtPkg::rowT     writeRow,
    input  ghtPkg::entryT   writeEntry,
    input  ghtPkg::counterT writeCounter,
    input  ghtPkg::rowT     readRow,
    input  ghtPkg::entryT   readEntry,
    output ghtPkg::counterT readCounter
);
    import ghtPkg::*;

    logic [RowWidth-1:0] rows [RowCount];

    logic [RowWidth-1:0] bitEn;
    logic [RowWidth-1:0] writeData;
    logic [RowWidth-1:0] rowData;
    counterT             groupCounter [16];

    // per-bit enables, a clear opens the whole row
    always_comb begin
        for (int e = 0; e < EntryCount; e++) begin
            bitEn[e*CounterWidth +: CounterWidth] =
                {CounterWidth{clearEn || writeEntry == entryT'(e)}};
            writeData[e*CounterWidth +: CounterWidth] = clearEn ? '0 : writeCounter;
        end
    end

    always_ff @(posedge clk) begin
        if (clearEn || writeEn) begin
            rows[writeRow] <= (rows[writeRow] & ~bitEn) | (writeData & bitEn);
        end
    end

    assign rowData = rows[readRow];

    // first level picks within each group of 16 entries
    always_comb begin
        for (int g = 0; g < 16; g++) begin
            groupCounter[g] =
                rowData[CounterWidth * (16 * g + int'(readEntry[3:0])) +: CounterWidth];
        end
    end

    // second level picks the group
    assign readCounter = groupCounter[readEntry[7:4]];

endmodule

// ==== verilog/writeScheduler.sv ====
module writeScheduler (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          update0Valid,
    input  ghtPkg::ghtIndexT              update0Index,
    input  ghtPkg::counterT               update0Counter,
    input  logic                          update1Valid,
    input  ghtPkg::ghtIndexT              update1Index,
    input  ghtPkg::counterT               update1Counter,
    output logic                          updateReady,
    output logic                          tableReady,
    output logic                          clearEn,
    output logic [ghtPkg::BankCount-1:0]  bankWriteEn,
    output ghtPkg::rowT                   bankWriteRow [ghtPkg::BankCount],
    output ghtPkg::entryT                 bankWriteEntry [ghtPkg::BankCount],
    output ghtPkg::counterT               bankWriteCounter [ghtPkg::BankCount]
);
    import ghtPkg::*;

    schedStateT state;
    rowT        sweepRow;

    // one-entry save buffer for port 1
    ghtIndexT savedIndex;
    counterT  savedCounter;

    logic take0;
    logic take1;
    logic conflict;
    bankT bank0;
    bankT bank1;
    bankT savedBank;

    assign tableReady  = (state != schedInit);
    assign updateReady = (state == schedRun);
    assign clearEn     = (state == schedInit) && !rst;

    assign take0 = update0Valid && updateReady;
    assign take1 = update1Valid && updateReady;

    assign bank0     = indexBank(update0Index);
    assign bank1     = indexBank(update1Index);
    assign savedBank = indexBank(savedIndex);

    // both ports into one bank, port 1 waits a cycle
    assign conflict = take0 && take1 && (bank0 == bank1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= schedInit;
            sweepRow <= '0;
        end else begin
            case (state)
                schedInit: begin
                    sweepRow <= sweepRow + 1'b1;
                    if (sweepRow == rowT'(RowCount - 1)) begin
                        state <= schedRun;
                    end
                end
                schedRun: begin
                    if (conflict) begin
                        state <= schedSaved;
                    end
                end
                schedSaved: begin
                    state <= schedRun;
                end
                default: begin
                    state <= schedInit;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (conflict) begin
            savedIndex   <= update1Index;
            savedCounter <= update1Counter;
        end
    end

    // steer each write to its bank
    always_comb begin
        for (int b = 0; b < BankCount; b++) begin
            bankWriteEn[b]      = 1'b0;
            bankWriteRow[b]     = indexRow(update0Index);
            bankWriteEntry[b]   = indexEntry(update0Index);
            bankWriteCounter[b] = update0Counter;
            if (state == schedInit) begin
                bankWriteRow[b] = sweepRow;
            end else if (state == schedSaved) begin
                if (savedBank == bankT'(b)) begin
                    bankWriteEn[b]      = 1'b1;
                    bankWriteRow[b]     = indexRow(savedIndex);
                    bankWriteEntry[b]   = indexEntry(savedIndex);
                    bankWriteCounter[b] = savedCounter;
                end
            end else if (take0 && bank0 == bankT'(b)) begin
                // port 0 wins the bank
                bankWriteEn[b] = 1'b1;
            end else if (take1 && bank1 == bankT'(b)) begin
                bankWriteEn[b]      = 1'b1;
                bankWriteRow[b]     = indexRow(update1Index);
                bankWriteEntry[b]   = indexEntry(update1Index);
                bankWriteCounter[b] = update1Counter;
            end
        end
    end

endmodule

// ==== verilog/lookupStage.sv ====
module lookupStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             tableReady,
    input  logic             lookupValid,
    input  ghtPkg::ghtIndexT lookupIp,
    input  ghtPkg::historyT  lookupHistory,
    output logic             lookupReady,
    output ghtPkg::rowT      readRow,
    output ghtPkg::entryT    readEntry,
    input  ghtPkg::counterT  bankCounter [ghtPkg::BankCount],
    output logic             predValid,
    output ghtPkg::counterT  predCounter
);
    import ghtPkg::*;

    ghtIndexT hashedIndex;
    ghtIndexT indexReg;
    bankT     bankSel;
    logic     transfer;

    // lookups only wait for the init sweep
    assign lookupReady = tableReady;
    assign transfer    = lookupValid && lookupReady;

    // history lands in the upper byte
    assign hashedIndex = lookupIp ^ {lookupHistory, {(IndexWidth - HistWidth){1'b0}}};

    always_ff @(posedge clk) begin
        if (transfer) begin
            indexReg <= hashedIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else begin
            predValid <= transfer;
        end
    end

    assign readRow   = indexRow(indexReg);
    assign readEntry = indexEntry(indexReg);
    assign bankSel   = indexBank(indexReg);

    // bank reads are combinational so this edge's writes show up
    assign predCounter = bankCounter[bankSel];

endmodule

// ==== verilog/ghtPredictor.sv ====
module ghtPredictor (
    input  logic             clk,
    input  logic             rst,
    input  logic             lookupValid,
    input  ghtPkg::ghtIndexT lookupIp,
    input  ghtPkg::historyT  lookupHistory,
    input  logic             update0Valid,
    input  ghtPkg::ghtIndexT update0Index,
    input  ghtPkg::counterT  update0Counter,
    input  logic             update1Valid,
    input  ghtPkg::ghtIndexT update1Index,
    input  ghtPkg::counterT  update1Counter,
    output logic             lookupReady,
    output logic             updateReady,
    output logic             predValid,
    output ghtPkg::counterT  predCounter
);
    import ghtPkg::*;

    logic                 tableReady;
    logic                 clearEn;
    logic [BankCount-1:0] bankWriteEn;
    rowT                  bankWriteRow [BankCount];
    entryT                bankWriteEntry [BankCount];
    counterT              bankWriteCounter [BankCount];

    rowT     readRow;
    entryT   readEntry;
    counterT bankCounter [BankCount];

    writeScheduler scheduler (
        .clk              (clk),
        .rst              (rst),
        .update0Valid     (update0Valid),
        .update0Index     (update0Index),
        .update0Counter   (update0Counter),
        .update1Valid     (update1Valid),
        .update1Index     (update1Index),
        .update1Counter   (update1Counter),
        .updateReady      (updateReady),
        .tableReady       (tableReady),
        .clearEn          (clearEn),
        .bankWriteEn      (bankWriteEn),
        .bankWriteRow     (bankWriteRow),
        .bankWriteEntry   (bankWriteEntry),
        .bankWriteCounter (bankWriteCounter)
    );

    lookupStage lookup (
        .clk           (clk),
        .rst           (rst),
        .tableReady    (tableReady),
        .lookupValid   (lookupValid),
        .lookupIp      (lookupIp),
        .lookupHistory (lookupHistory),
        .lookupReady   (lookupReady),
        .readRow       (readRow),
        .readEntry     (readEntry),
        .bankCounter   (bankCounter),
        .predValid     (predValid),
        .predCounter   (predCounter)
    );

    // all banks share the read address
    for (genvar b = 0; b < BankCount; b++) begin : bankSlot
        historyBank bank (
            .clk          (clk),
            .writeEn      (bankWriteEn[b]),
            .clearEn      (clearEn),
            .writeRow     (bankWriteRow[b]),
            .writeEntry   (bankWriteEntry[b]),
            .writeCounter (bankWriteCounter[b]),
            .readRow      (readRow),
            .readEntry    (readEntry),
            .readCounter  (bankCounter[b])
        );
    end

endmodule

// ==== bench/ghtModel.svh ====
`ifndef GHT_MODEL_SVH
`define GHT_MODEL_SVH

// one counter per full 16-bit index
counterT  modelTable [65536];
logic     tableUp;
int       sweepEdges;

// port 1 write held back after a bank clash
logic     heldValid;
ghtIndexT heldIndex;
counterT  heldCounter;

// history goes into the upper byte
function automatic ghtIndexT hashIndex(input ghtIndexT ip, input historyT hist);
    return ip ^ {hist, 8'h00};
endfunction

function automatic bankT bankOf(input ghtIndexT idx);
    return {idx[7:6], idx[0]};
endfunction

// ip that lands on idx for a given history
function automatic ghtIndexT ipFor(input ghtIndexT idx, input historyT hist);
    return idx ^ {hist, 8'h00};
endfunction

task automatic resetModel();
    for (int i = 0; i < 65536; i++) begin
        modelTable[i] = '0;
    end
    tableUp    = 1'b0;
    sweepEdges = 0;
    heldValid  = 1'b0;
    heldIndex  = '0;
    heldCounter = '0;
endtask

// one rising edge with rst low
task automatic modelEdge(
    input  logic     v0,
    input  ghtIndexT i0,
    input  counterT  c0,
    input  logic     v1,
    input  ghtIndexT i1,
    input  counterT  c1,
    output logic     took0,
    output logic     took1
);
    took0 = 1'b0;
    took1 = 1'b0;
    if (!tableUp) begin
        sweepEdges++;
        if (sweepEdges == RowCount) begin
            tableUp = 1'b1;
        end
    end else if (heldValid) begin
        modelTable[heldIndex] = heldCounter;
        heldValid = 1'b0;
    end else begin
        took0 = v0;
        took1 = v1;
        if (v0) begin
            modelTable[i0] = c0;
        end
        if (v0 && v1 && bankOf(i0) == bankOf(i1)) begin
            heldValid   = 1'b1;
            heldIndex   = i1;
            heldCounter = c1;
        end else if (v1) begin
            modelTable[i1] = c1;
        end
    end
endtask

`endif

// ==== bench/ghtPredictorTb.sv ====
module ghtPredictorTb;
    import ghtPkg::*;

    localparam int ResetCycles   = 5;
    localparam int ClearLookups  = 200;
    localparam int SingleUpdates = 100;
    localparam int ConflictPairs = 40;
    localparam int RandomCycles  = 2000;
    localparam int OpCount       = ClearLookups + 2 * SingleUpdates + 3 * ConflictPairs
                                   + RandomCycles;
    localparam int CycleLimit    = ResetCycles + RowCount + 3 * OpCount + 100;

    logic     clk = 1'b0;
    logic     rst;
    logic     lookupValid;
    ghtIndexT lookupIp;
    historyT  lookupHistory;
    logic     update0Valid;
    ghtIndexT update0Index;
    counterT  update0Counter;
    logic     update1Valid;
    ghtIndexT update1Index;
    counterT  update1Counter;
    logic     lookupReady;
    logic     updateReady;
    logic     predValid;
    counterT  predCounter;

    int cycleCount = 0;

    `include "ghtModel.svh"

    ghtPredictor UUT (
        .clk            (clk),
        .rst            (rst),
        .lookupValid    (lookupValid),
        .lookupIp       (lookupIp),
        .lookupHistory  (lookupHistory),
        .update0Valid   (update0Valid),
        .update0Index   (update0Index),
        .update0Counter (update0Counter),
        .update1Valid   (update1Valid),
        .update1Index   (update1Index),
        .update1Counter (update1Counter),
        .lookupReady    (lookupReady),
        .updateReady    (updateReady),
        .predValid      (predValid),
        .predCounter    (predCounter)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: %s is 0x%h, expected 0x%h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic setIdle();
        lookupValid    = 1'b0;
        lookupIp       = '0;
        lookupHistory  = '0;
        update0Valid   = 1'b0;
        update0Index   = '0;
        update0Counter = '0;
        update1Valid   = 1'b0;
        update1Index   = '0;
        update1Counter = '0;
    endtask

    // inputs are already driven, model the edge then check after it
    task automatic clockEdge(output logic took0, output logic took1);
        logic    lookTaken;
        counterT expPred;
        lookTaken = lookupValid && tableUp;
        modelEdge(update0Valid, update0Index, update0Counter,
                  update1Valid, update1Index, update1Counter, took0, took1);
        expPred = modelTable[hashIndex(lookupIp, lookupHistory)];
        @(negedge clk);
        checkValue("predValid", 32'(predValid), 32'(lookTaken));
        if (lookTaken) begin
            checkValue("predCounter", 32'(predCounter), 32'(expPred));
        end
        checkValue("lookupReady", 32'(lookupReady), 32'(tableUp));
        checkValue("updateReady", 32'(updateReady), 32'(tableUp && !heldValid));
    endtask

    initial begin
        logic        took0;
        logic        took1;
        ghtIndexT    idx0;
        ghtIndexT    idx1;
        counterT     cnt0;
        counterT     cnt1;
        historyT     hist;
        logic [31:0] r;
        logic [31:0] r2;
        ghtIndexT    recent [$];

        void'($urandom(32'hca0f_d0b0));
        rst = 1'b1;
        setIdle();
        resetModel();

        repeat (ResetCycles) begin
            @(negedge clk);
            checkValue("lookupReady", 32'(lookupReady), 32'h0);
            checkValue("updateReady", 32'(updateReady), 32'h0);
            checkValue("predValid", 32'(predValid), 32'h0);
        end
        rst = 1'b0;

        // init sweep, readies checked low every cycle until row 31 is cleared
        while (!tableUp) begin
            clockEdge(took0, took1);
        end

        // cleared table, back to back lookups
        for (int n = 0; n < ClearLookups; n++) begin
            lookupValid   = 1'b1;
            lookupIp      = ghtIndexT'($urandom());
            lookupHistory = historyT'($urandom());
            clockEdge(took0, took1);
            checkValue("predCounter", 32'(predCounter), 32'h0);
        end

        // single writes on port 0, read in the same and the next cycle
        for (int n = 0; n < SingleUpdates; n++) begin
            idx0 = ghtIndexT'($urandom());
            cnt0 = counterT'($urandom());
            hist = historyT'($urandom());
            update0Valid   = 1'b1;
            update0Index   = idx0;
            update0Counter = cnt0;
            lookupValid    = 1'b1;
            lookupHistory  = hist;
            lookupIp       = ipFor(idx0, hist);
            took0 = 1'b0;
            while (!took0) begin
                clockEdge(took0, took1);
            end
            checkValue("predCounter", 32'(predCounter), 32'(cnt0));
            update0Valid = 1'b0;
            clockEdge(took0, took1);
            checkValue("predCounter", 32'(predCounter), 32'(cnt0));
        end
        setIdle();

        // both ports into one bank
        for (int n = 0; n < ConflictPairs; n++) begin
            r    = $urandom();
            idx0 = ghtIndexT'($urandom());
            idx1 = {r[15:8], idx0[7:6], r[5:1], idx0[0]};
            if (n % 4 == 0) begin
                idx1 = idx0;
            end
            cnt0 = counterT'($urandom());
            cnt1 = counterT'($urandom());
            if (idx1 == idx0 && cnt1 == cnt0) begin
                cnt1 = ~cnt0;
            end
            hist = historyT'($urandom());
            update0Valid   = 1'b1;
            update0Index   = idx0;
            update0Counter = cnt0;
            update1Valid   = 1'b1;
            update1Index   = idx1;
            update1Counter = cnt1;
            lookupValid    = 1'b1;
            lookupHistory  = hist;
            lookupIp       = ipFor(idx1, hist);
            clockEdge(took0, took1);
            checkValue("updateReady", 32'(updateReady), 32'h0);
            update0Valid = 1'b0;
            update1Valid = 1'b0;
            clockEdge(took0, took1);
            checkValue("predCounter", 32'(predCounter), 32'(cnt1));
            checkValue("updateReady", 32'(updateReady), 32'h1);
            lookupIp = ipFor(idx0, hist);
            clockEdge(took0, took1);
            checkValue("predCounter", 32'(predCounter), idx1 == idx0 ? 32'(cnt1) : 32'(cnt0));
        end
        setIdle();

        // random traffic, updaters hold their request until taken
        for (int n = 0; n < RandomCycles; n++) begin
            r  = $urandom();
            r2 = $urandom();
            lookupValid   = r[1:0] != 2'b00;
            lookupHistory = historyT'($urandom());
            if (r[2] && recent.size() > 0) begin
                lookupIp = ipFor(recent[$urandom_range(recent.size() - 1, 0)], lookupHistory);
            end else begin
                lookupIp = ghtIndexT'($urandom());
            end
            if (!update0Valid && r[3]) begin
                update0Valid   = 1'b1;
                update0Index   = ghtIndexT'($urandom());
                update0Counter = counterT'($urandom());
            end
            if (!update1Valid && r[4]) begin
                update1Valid   = 1'b1;
                update1Index   = ghtIndexT'($urandom());
                update1Counter = counterT'($urandom());
                if (update0Valid && r[5]) begin
                    update1Index = {r2[15:8], update0Index[7:6], r2[5:1], update0Index[0]};
                end
                if (update0Valid && r[6] && r[7]) begin
                    update1Index = update0Index;
                end
            end
            clockEdge(took0, took1);
            if (took0) begin
                recent.push_back(update0Index);
                update0Valid = 1'b0;
            end
            if (took1) begin
                recent.push_back(update1Index);
                update1Valid = 1'b0;
            end
            while (recent.size() > 16) begin
                void'(recent.pop_front());
            end
        end

        setIdle();
        clockEdge(took0, took1);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+bench
verilog/ghtPkg.sv
verilog/historyBank.sv
verilog/writeScheduler.sv
verilog/lookupStage.sv
verilog/ghtPredictor.sv
bench/ghtPredictorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module ghtPredictorTb -f compile.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
